//--- vid_params.svh
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// ==============================
// Video stream sizes
// ==============================
// Grey pixel width in bits
`define VID_PIX_W 8
// Active pixels per line, also the line buffer depth
`define VID_H_RES 172

// ==============================
// APB bus sizes
// ==============================
`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

//--- vid_pkg.sv
`include "vid_params.svh"

package vid_pkg;

    // One grey pixel
    typedef logic [`VID_PIX_W-1:0] pix_t;

    // Kernel weights add up to 16, so 4 extra bits hold any sum
    typedef logic [`VID_PIX_W+3:0] sum_t;

    // Index into one line buffer
    typedef logic [$clog2(`VID_H_RES)-1:0] col_ptr_t;

    // Raster timing bits of one beat
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } vid_sync_t;

    // One clock of the stream
    typedef struct packed {
        vid_sync_t sync;
        pix_t      pix;
    } vid_beat_t;

    // 3x3 neighbourhood, row 1 oldest line, column 1 oldest pixel
    typedef struct packed {
        pix_t p11, p12, p13;
        pix_t p21, p22, p23;
        pix_t p31, p32, p33;
    } win3_t;

endpackage

//--- apb_pkg.sv
`include "vid_params.svh"

package apb_pkg;

    // Bus widths
    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

    // ==============================
    // Bus bundles
    // ==============================
    // Master to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic      pready;
        logic      pslverr;
        apb_data_t prdata;
    } apb_rsp_t;

    // Register map, anything else is unmapped
    typedef enum apb_addr_t {
        REG_CTRL   = `APB_ADDR_W'('h00),
        REG_FRAMES = `APB_ADDR_W'('h04)
    } csr_addr_e;

endpackage

//--- line_window.sv
`include "vid_params.svh"

module line_window (
    input  logic               clk,
    input  logic               rstn,
    input  vid_pkg::vid_beat_t i_beat,
    output vid_pkg::win3_t     o_win,
    output vid_pkg::vid_sync_t o_sync
);

    // ==============================
    // Line buffers
    // ==============================
    // Previous line
    vid_pkg::pix_t lb_new [`VID_H_RES] = '{default: '0};
    // Line before the previous one
    vid_pkg::pix_t lb_old [`VID_H_RES] = '{default: '0};

    // Shared write pointer, same column in both buffers
    vid_pkg::col_ptr_t wr_ptr;

    // Column read ahead of the write
    vid_pkg::pix_t rd_new;
    vid_pkg::pix_t rd_old;

    assign rd_new = lb_new[wr_ptr];
    assign rd_old = lb_old[wr_ptr];

    // Cascade on each active pixel
    always_ff @(posedge clk) begin
        if (i_beat.sync.de) begin
            lb_new[wr_ptr] <= i_beat.pix;
            lb_old[wr_ptr] <= rd_new;
        end
    end

    // Pointer wraps at the end of a line
    // Not realigned at frame start
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (i_beat.sync.de) begin
            if (wr_ptr == vid_pkg::col_ptr_t'(`VID_H_RES - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // ==============================
    // 3x3 window
    // ==============================
    // Column 3 takes the new pixels, older ones move left
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_win <= '0;
        end else if (i_beat.sync.de) begin
            o_win.p13 <= rd_old;
            o_win.p12 <= o_win.p13;
            o_win.p11 <= o_win.p12;
            o_win.p23 <= rd_new;
            o_win.p22 <= o_win.p23;
            o_win.p21 <= o_win.p22;
            o_win.p33 <= i_beat.pix;
            o_win.p32 <= o_win.p33;
            o_win.p31 <= o_win.p32;
        end
    end

    // Sync follows every cycle, one clock like the window
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_sync <= '0;
        end else begin
            o_sync <= i_beat.sync;
        end
    end

    a_ptr_range: assert property (@(posedge clk) disable iff (!rstn)
        wr_ptr < `VID_H_RES)
        else $error("line_window pointer left the line buffer range");

endmodule

//--- gauss_kernel.sv
`include "vid_params.svh"

module gauss_kernel (
    input  logic               clk,
    input  logic               rstn,
    input  vid_pkg::win3_t     i_win,
    input  vid_pkg::vid_sync_t i_sync,
    input  logic               i_blur_en,
    output vid_pkg::vid_beat_t o_beat
);

    // Weighted sum before the stage 1 register
    vid_pkg::sum_t weighted;

    // Stage 1
    vid_pkg::sum_t sum_q;
    vid_pkg::pix_t centre_q;

    // Stage 2
    vid_pkg::pix_t pix_q;

    // Sync shift register, index 1 is the output
    vid_pkg::vid_sync_t [1:0] sync_d;

    // ==============================
    // Stage 1 weighted sum
    // ==============================
    // Kernel 1 2 1 / 2 4 2 / 1 2 1
    // Weights by shifts, widened first so nothing is lost
    always_comb begin
        weighted = vid_pkg::sum_t'(i_win.p11)
                 + (vid_pkg::sum_t'(i_win.p12) << 1)
                 + vid_pkg::sum_t'(i_win.p13)
                 + (vid_pkg::sum_t'(i_win.p21) << 1)
                 + (vid_pkg::sum_t'(i_win.p22) << 2)
                 + (vid_pkg::sum_t'(i_win.p23) << 1)
                 + vid_pkg::sum_t'(i_win.p31)
                 + (vid_pkg::sum_t'(i_win.p32) << 1)
                 + vid_pkg::sum_t'(i_win.p33);
    end

    // Centre kept for bypass
    always_ff @(posedge clk) begin
        sum_q    <= weighted;
        centre_q <= i_win.p22;
    end

    // ==============================
    // Stage 2 divide and select
    // ==============================
    // Upper bits of the sum give the divide by 16
    always_ff @(posedge clk) begin
        pix_q <= i_blur_en ? sum_q[`VID_PIX_W+3:4] : centre_q;
    end

    // Two clocks of sync to match the arithmetic
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_d <= '0;
        end else begin
            sync_d <= {sync_d[0], i_sync};
        end
    end

    assign o_beat.sync = sync_d[1];
    assign o_beat.pix  = pix_q;

    a_sync_delay: assert property (@(posedge clk) disable iff (!rstn)
        o_beat.sync == $past(i_sync, 2))
        else $error("gauss_kernel sync is not two cycles behind its input");

endmodule

//--- apb_csr.sv
module apb_csr (
    input  logic              clk,
    input  logic              rstn,
    input  apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t o_apb,
    input  logic              i_out_vsync,
    output logic              o_blur_en
);

    // Access phase of any transfer
    logic access;

    // Address decode result
    logic               addr_hit;
    apb_pkg::apb_data_t rd_data;

    // Control register bit 0
    logic blur_en_q;

    // Output frame counter and vsync edge detect
    apb_pkg::apb_data_t frame_cnt;
    logic               vsync_q;

    assign access = i_apb.psel & i_apb.penable;

    // ==============================
    // Address decode
    // ==============================
    // Unmapped addresses read back as zero
    always_comb begin
        addr_hit = 1'b0;
        rd_data  = '0;
        case (i_apb.paddr)
            apb_pkg::REG_CTRL: begin
                addr_hit = 1'b1;
                rd_data  = apb_pkg::apb_data_t'(blur_en_q);
            end
            apb_pkg::REG_FRAMES: begin
                addr_hit = 1'b1;
                rd_data  = frame_cnt;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // No wait states
    always_comb begin
        o_apb.pready  = access;
        o_apb.pslverr = access & ~addr_hit;
        o_apb.prdata  = (access & ~i_apb.pwrite) ? rd_data : '0;
    end

    // ==============================
    // Registers
    // ==============================
    // Only REG_CTRL is writable, blur on out of reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blur_en_q <= 1'b1;
        end else if (access && i_apb.pwrite && i_apb.paddr == apb_pkg::REG_CTRL) begin
            blur_en_q <= i_apb.pwdata[0];
        end
    end

    assign o_blur_en = blur_en_q;

    // One count per rising vsync on the output, wraps at 2^32
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vsync_q <= i_out_vsync;
            if (i_out_vsync && !vsync_q) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rstn)
        i_apb.penable |-> i_apb.psel)
        else $error("apb_csr saw penable without psel");

endmodule

//--- video_filter_top.sv
module video_filter_top (
    input  logic               clk,
    input  logic               rstn,
    input  vid_pkg::vid_beat_t i_beat,
    output vid_pkg::vid_beat_t o_beat,
    input  apb_pkg::apb_req_t  i_apb,
    output apb_pkg::apb_rsp_t  o_apb
);

    // ==============================
    // Internal links
    // ==============================
    // Window and its sync, one cycle after the input
    vid_pkg::win3_t     win;
    vid_pkg::vid_sync_t win_sync;

    // Blur enable from the register block
    logic blur_en;

    // Line buffers and 3x3 window
    line_window u_line_window (
        .clk    (clk),
        .rstn   (rstn),
        .i_beat (i_beat),
        .o_win  (win),
        .o_sync (win_sync)
    );

    // Weighted sum or bypass, two more cycles
    gauss_kernel u_gauss_kernel (
        .clk       (clk),
        .rstn      (rstn),
        .i_win     (win),
        .i_sync    (win_sync),
        .i_blur_en (blur_en),
        .o_beat    (o_beat)
    );

    // Register block
    // Frames counted on the outgoing vsync
    apb_csr u_apb_csr (
        .clk         (clk),
        .rstn        (rstn),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .i_out_vsync (o_beat.sync.vsync),
        .o_blur_en   (blur_en)
    );

endmodule

//--- tb_clkgen.sv
module tb_clkgen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held low for the first 4 rising edges
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- tb_video_filter.sv
`include "vid_params.svh"

module tb_video_filter;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_RES    = `VID_H_RES;
    localparam int TIMEOUT  = 1000;
    localparam int N_FRAMES = 5;

    // Pattern kinds
    localparam logic [1:0] PAT_RAMP  = 2'd0;
    localparam logic [1:0] PAT_CONST = 2'd1;
    localparam logic [1:0] PAT_RAND  = 2'd2;

    // One table entry per frame
    typedef struct packed {
        logic       blur;
        logic [1:0] kind;
        logic [7:0] lines;
    } frame_cfg_t;

    // Expected output beat, act marks a pixel to compare
    typedef struct packed {
        vid_pkg::vid_sync_t sync;
        vid_pkg::pix_t      pix;
        logic               act;
    } exp_beat_t;

    // Blur off in frame 3, back on after it
    frame_cfg_t frame_tbl [N_FRAMES] = '{
        '{1'b1, PAT_RAMP,  8'd3},
        '{1'b1, PAT_RAND,  8'd4},
        '{1'b0, PAT_RAND,  8'd3},
        '{1'b1, PAT_CONST, 8'd2},
        '{1'b1, PAT_RAND,  8'd3}
    };

    logic               clk;
    logic               rstn;
    vid_pkg::vid_beat_t beat_in;
    vid_pkg::vid_beat_t beat_out;
    apb_pkg::apb_req_t  apb_req;
    apb_pkg::apb_rsp_t  apb_rsp;

    integer seed = 32'hd26c_084e;

    // Model state
    vid_pkg::pix_t stream_s [$];
    exp_beat_t     exp_q [$];
    int            pending_act;
    logic          blur_model;
    logic          mon_on;
    int            frames_sent;
    int            err_cnt;

    tb_clkgen u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    video_filter_top video_filter_top_inst (
        .clk    (clk),
        .rstn   (rstn),
        .i_beat (beat_in),
        .o_beat (beat_out),
        .i_apb  (apb_req),
        .o_apb  (apb_rsp)
    );

    // ==============================
    // Failure handling
    // ==============================
    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s", $time, what);
        stop_on_failure();
    endtask

    // ==============================
    // Reference model
    // ==============================
    // Pixels before the first one count as zero
    function automatic int s_at(input int idx);
        if (idx < 0) return 0;
        return int'(stream_s[idx]);
    endfunction

    // Row r back by lines, column k back by pixels
    function automatic vid_pkg::pix_t model_pix(input int n, input logic blur);
        int acc;
        int w;
        acc = 0;
        if (!blur) return vid_pkg::pix_t'(s_at(n - H_RES - 1));
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 3; k++) begin
                // Middle row and column weigh double
                w = (r == 1 ? 2 : 1) * (k == 1 ? 2 : 1);
                acc += w * s_at(n - r * H_RES - k);
            end
        end
        return vid_pkg::pix_t'(acc / 16);
    endfunction

    // Sample input and output mid-cycle, compare 3 cycles apart
    always @(negedge clk) begin : beat_monitor
        exp_beat_t e;
        if (mon_on) begin
            e.sync = beat_in.sync;
            e.act  = beat_in.sync.de;
            e.pix  = '0;
            if (beat_in.sync.de) begin
                stream_s.push_back(beat_in.pix);
                e.pix = model_pix(stream_s.size() - 1, blur_model);
                pending_act++;
            end
            exp_q.push_back(e);
            e = exp_q.pop_front();
            check_val("output sync", 32'(beat_out.sync), 32'(e.sync));
            if (e.act) begin
                check_val("output pixel", 32'(beat_out.pix), 32'(e.pix));
                pending_act--;
            end
        end
    end

    // ==============================
    // Stimulus tasks
    // ==============================
    task automatic drive_beat(input logic vs, input logic hs, input logic de,
                              input vid_pkg::pix_t pix);
        @(posedge clk);
        beat_in <= {vs, hs, de, pix};
    endtask

    function automatic vid_pkg::pix_t gen_pix(input logic [1:0] kind, input int line,
                                              input int col);
        case (kind)
            PAT_RAMP:  return vid_pkg::pix_t'(line * 7 + col);
            PAT_CONST: return 8'hc8;
            default:   return vid_pkg::pix_t'($random(seed));
        endcase
    endfunction

    // Vsync pulse, then lines with hsync blanking
    task automatic send_frame(input frame_cfg_t cfg);
        repeat (2) drive_beat(1'b1, 1'b0, 1'b0, '0);
        repeat (4) drive_beat(1'b0, 1'b0, 1'b0, '0);
        for (int ln = 0; ln < int'(cfg.lines); ln++) begin
            repeat (3) drive_beat(1'b0, 1'b1, 1'b0, '0);
            repeat (3) drive_beat(1'b0, 1'b0, 1'b0, '0);
            for (int col = 0; col < H_RES; col++) begin
                drive_beat(1'b0, 1'b0, 1'b1, gen_pix(cfg.kind, ln, col));
            end
        end
        drive_beat(1'b0, 1'b0, 1'b0, '0);
        frames_sent++;
    endtask

    task automatic wait_reset();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!rstn) begin
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("reset was never released");
            @(negedge clk);
        end
    endtask

    // Until every queued active pixel has left the DUT
    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (pending_act != 0) begin
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("active pixels did not leave the pipeline");
            @(posedge clk);
        end
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_xfer(input logic wr, input apb_pkg::apb_addr_t addr,
                            input apb_pkg::apb_data_t wdata,
                            output apb_pkg::apb_data_t rdata, output logic err);
        int cnt;
        cnt = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("APB pready did not rise in the access phase");
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        apb_pkg::apb_data_t rd;
        logic               err;
        beat_in     = '0;
        apb_req     = '0;
        mon_on      = 1'b0;
        pending_act = 0;
        blur_model  = 1'b1;
        frames_sent = 0;
        err_cnt     = 0;

        wait_reset();
        @(posedge clk);
        check_val("sync after reset", 32'(beat_out.sync), 32'h0);
        check_val("pready after reset", 32'(apb_rsp.pready), 32'h0);
        check_val("pslverr after reset", 32'(apb_rsp.pslverr), 32'h0);

        // Pipeline holds idle beats out of reset
        repeat (3) exp_q.push_back('0);
        mon_on = 1'b1;

        apb_xfer(1'b0, apb_pkg::REG_CTRL, '0, rd, err);
        check_val("REG_CTRL reset value", rd, 32'h1);
        apb_xfer(1'b0, apb_pkg::REG_FRAMES, '0, rd, err);
        check_val("REG_FRAMES reset value", rd, 32'h0);

        for (int f = 0; f < N_FRAMES; f++) begin
            // Enable changes only while the stream is idle
            apb_xfer(1'b1, apb_pkg::REG_CTRL, 32'(frame_tbl[f].blur), rd, err);
            check_val("REG_CTRL write pslverr", 32'(err), 32'h0);
            blur_model = frame_tbl[f].blur;
            send_frame(frame_tbl[f]);
            wait_drain();
            apb_xfer(1'b0, apb_pkg::REG_FRAMES, '0, rd, err);
            check_val("frame count", rd, 32'(frames_sent));
        end

        // Unmapped read and write
        apb_xfer(1'b0, 8'h08, '0, rd, err);
        check_val("unmapped read pslverr", 32'(err), 32'h1);
        check_val("unmapped read data", rd, 32'h0);
        apb_xfer(1'b1, 8'h0c, 32'h0, rd, err);
        check_val("unmapped write pslverr", 32'(err), 32'h1);
        apb_xfer(1'b0, apb_pkg::REG_CTRL, '0, rd, err);
        check_val("REG_CTRL after unmapped write", rd, 32'(frame_tbl[N_FRAMES-1].blur));

        // Frame counter is read only
        // Bit 0 clear in the data so a stray REG_CTRL write would show
        apb_xfer(1'b1, apb_pkg::REG_FRAMES, 32'haa, rd, err);
        check_val("REG_FRAMES write pslverr", 32'(err), 32'h0);
        apb_xfer(1'b0, apb_pkg::REG_FRAMES, '0, rd, err);
        check_val("frame count after write", rd, 32'(frames_sent));
        apb_xfer(1'b0, apb_pkg::REG_CTRL, '0, rd, err);
        check_val("REG_CTRL after REG_FRAMES write", rd, 32'(frame_tbl[N_FRAMES-1].blur));

        if (err_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

//--- list.f
+incdir+.
vid_pkg.sv
apb_pkg.sv
line_window.sv
gauss_kernel.sv
apb_csr.sv
video_filter_top.sv
tb_clkgen.sv
tb_video_filter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video filter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_video_filter \
    -f list.f

# The log decides the result
./obj_dir/Vtb_video_filter > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
